//--- design/cache_lookup_pkg.sv
// cache lookup shared definitions
package cache_lookup_pkg;

  // ====================
  // cache geometry
  // ====================
  localparam int NUM_WAYS        = 4;
  localparam int WAY_WIDTH       = 2;
  localparam int NUM_SETS        = 16;
  localparam int SET_WIDTH       = 4;
  localparam int NUM_WORDS_IN_CL = 4;
  localparam int WORD_WIDTH      = 32;
  localparam int OFFSET_WIDTH    = 2;
  localparam int TAG_WIDTH       = 8;
  localparam int ADDR_WIDTH      = 16;

  // address fields: tag | set | word offset | 2'b00
  localparam int LSB_OFFSET = 2;
  localparam int MSB_OFFSET = LSB_OFFSET + OFFSET_WIDTH - 1;
  localparam int LSB_SET    = MSB_OFFSET + 1;
  localparam int MSB_SET    = LSB_SET + SET_WIDTH - 1;
  localparam int LSB_TAG    = MSB_SET + 1;
  localparam int MSB_TAG    = LSB_TAG + TAG_WIDTH - 1;

  // ====================
  // lookup types
  // ====================
  typedef enum logic [1:0] {RD_LU, WR_LU, FILL_LU} t_lu_op;
  typedef enum logic [1:0] {HIT, MISS, NO_RSP} t_lu_result;

  // one cache line, word 0 in the low bits
  typedef logic [NUM_WORDS_IN_CL-1:0][WORD_WIDTH-1:0] t_cl;

  typedef struct packed {
    t_lu_op                lu_op;
    logic [ADDR_WIDTH-1:0] address;
    logic [WORD_WIDTH-1:0] data;
    t_cl                   cl_data;
  } t_lu_req;

  typedef struct packed {
    t_lu_result            lu_result;
    logic [ADDR_WIDTH-1:0] address;
    t_cl                   data;
  } t_lu_rsp;

endpackage

//--- design/lu_fifo.sv
// lookup payload FIFO
module lu_fifo #(
  parameter int  DEPTH     = 4,
  parameter type t_payload = logic
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     enq_valid,
  output logic                     enq_ready,
  input  t_payload                 enq_payload,
  output logic                     deq_valid,
  input  logic                     deq_ready,
  output t_payload                 deq_payload,
  output logic [$clog2(DEPTH):0]   free_count
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  t_payload           mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic [CNT_W-1:0]   count_nxt;
  logic               push;
  logic               pop;
  logic               not_empty_q;
  logic               not_full_q;

  assign push      = enq_valid && not_full_q;
  assign pop       = not_empty_q && deq_ready;
  // pointers wrap naturally, DEPTH is a power of two
  assign count_nxt = count_q + CNT_W'(push) - CNT_W'(pop);

  // ====================
  // control state
  // ====================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      not_empty_q <= 1'b0;
      not_full_q  <= 1'b1;
    end else begin
      wr_ptr_q    <= wr_ptr_q + PTR_W'(push);
      rd_ptr_q    <= rd_ptr_q + PTR_W'(pop);
      count_q     <= count_nxt;
      // flags follow the next count
      not_empty_q <= (count_nxt != '0);
      not_full_q  <= (count_nxt != CNT_W'(DEPTH));
    end
  end

  // storage, no reset
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= enq_payload;
    end
  end

  assign enq_ready   = not_full_q;
  assign deq_valid   = not_empty_q;
  assign deq_payload = mem[rd_ptr_q];
  // space left, used as response credit
  assign free_count  = CNT_W'(DEPTH) - count_q;

endmodule

//--- design/tag_array.sv
// set tag and state storage
module tag_array
  import cache_lookup_pkg::*;
(
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                rd_en,
  input  logic [SET_WIDTH-1:0]                rd_set,
  output logic [NUM_WAYS-1:0]                 rd_valid,
  output logic [NUM_WAYS-1:0][TAG_WIDTH-1:0]  rd_tags,
  output logic [NUM_WAYS-1:0]                 rd_mru,
  input  logic                                wr_en,
  input  logic [SET_WIDTH-1:0]                wr_set,
  input  logic [NUM_WAYS-1:0]                 wr_way_mask,
  input  logic [TAG_WIDTH-1:0]                wr_tag,
  input  logic [NUM_WAYS-1:0]                 wr_mru
);

  // per-set flags, cleared on reset
  logic [NUM_SETS-1:0][NUM_WAYS-1:0]  valid_q;
  logic [NUM_SETS-1:0][NUM_WAYS-1:0]  mru_q;
  // tags need no reset, valid guards them
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tags_mem [NUM_SETS];

  // ====================
  // valid and MRU
  // ====================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q  <= '0;
      mru_q    <= '0;
      rd_valid <= '0;
      rd_mru   <= '0;
    end else begin
      if (wr_en) begin
        // valid only on masked ways, MRU on the whole set
        valid_q[wr_set] <= valid_q[wr_set] | wr_way_mask;
        mru_q[wr_set]   <= wr_mru;
      end
      // read sees the state before a same-edge write
      if (rd_en) begin
        rd_valid <= valid_q[rd_set];
        rd_mru   <= mru_q[rd_set];
      end
    end
  end

  // ====================
  // tag storage
  // ====================
  always_ff @(posedge clk) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wr_en && wr_way_mask[w]) begin
        tags_mem[wr_set][w] <= wr_tag;
      end
    end
    if (rd_en) begin
      rd_tags <= tags_mem[rd_set];
    end
  end

endmodule

//--- design/data_array.sv
// cache line storage
module data_array
  import cache_lookup_pkg::*;
(
  input  logic                           clk,
  input  logic                           rd_en,
  input  logic [SET_WIDTH+WAY_WIDTH-1:0] rd_addr,
  output t_cl                            rd_line,
  input  logic                           wr_en,
  input  logic [SET_WIDTH+WAY_WIDTH-1:0] wr_addr,
  input  t_cl                            wr_line
);

  // one entry per {set, way}
  localparam int NUM_LINES = NUM_SETS * NUM_WAYS;

  t_cl lines_mem [NUM_LINES];

  // ====================
  // write port
  // ====================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      lines_mem[wr_addr] <= wr_line;
    end
  end

  // ====================
  // registered read
  // ====================
  // a same-edge write is not seen here
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_line <= lines_mem[rd_addr];
    end
  end

endmodule

//--- design/cache_pipe.sv
// three-stage lookup pipeline
module cache_pipe
  import cache_lookup_pkg::*;
#(
  parameter int RSP_FIFO_DEPTH = 4
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                req_valid,
  output logic                                req_ready,
  input  t_lu_req                             req,
  input  logic [$clog2(RSP_FIFO_DEPTH):0]     rsp_free,
  output logic                                rsp_valid,
  output t_lu_rsp                             rsp,
  output logic                                tag_rd_en,
  output logic [SET_WIDTH-1:0]                tag_rd_set,
  input  logic [NUM_WAYS-1:0]                 tag_rd_valid,
  input  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0]  tag_rd_tags,
  input  logic [NUM_WAYS-1:0]                 tag_rd_mru,
  output logic                                tag_wr_en,
  output logic [SET_WIDTH-1:0]                tag_wr_set,
  output logic [NUM_WAYS-1:0]                 tag_wr_way_mask,
  output logic [TAG_WIDTH-1:0]                tag_wr_tag,
  output logic [NUM_WAYS-1:0]                 tag_wr_mru,
  output logic                                data_rd_en,
  output logic [SET_WIDTH+WAY_WIDTH-1:0]      data_rd_addr,
  input  t_cl                                 data_rd_line,
  output logic                                data_wr_en,
  output logic [SET_WIDTH+WAY_WIDTH-1:0]      data_wr_addr,
  output t_cl                                 data_wr_line
);

  localparam int FREE_W = $clog2(RSP_FIFO_DEPTH) + 1;

  logic                    accept;
  logic                    hazard;
  logic [FREE_W-1:0]       in_flight;
  logic [SET_WIDTH-1:0]    q1_set;
  // q2 stage
  logic                    q2_valid_q;
  t_lu_op                  q2_op_q;
  logic [TAG_WIDTH-1:0]    q2_tag_q;
  logic [SET_WIDTH-1:0]    q2_set_q;
  logic [OFFSET_WIDTH-1:0] q2_offset_q;
  logic [WORD_WIDTH-1:0]   q2_data_q;
  t_cl                     q2_cl_data_q;
  logic [NUM_WAYS-1:0]     hit_vec;
  logic                    q2_hit;
  logic [WAY_WIDTH-1:0]    hit_way;
  logic [WAY_WIDTH-1:0]    victim_way;
  logic [WAY_WIDTH-1:0]    q2_way;
  logic [NUM_WAYS-1:0]     way_onehot;
  logic [NUM_WAYS-1:0]     mru_set;
  // q3 stage
  logic                    q3_valid_q;
  t_lu_op                  q3_op_q;
  logic                    q3_hit_q;
  logic [TAG_WIDTH-1:0]    q3_tag_q;
  logic [SET_WIDTH-1:0]    q3_set_q;
  logic [OFFSET_WIDTH-1:0] q3_offset_q;
  logic [WORD_WIDTH-1:0]   q3_data_q;
  t_cl                     q3_cl_data_q;
  logic [WAY_WIDTH-1:0]    q3_way_q;
  t_cl                     merged_line;

  // ====================
  // q1 issue
  // ====================
  assign q1_set = req.address[MSB_SET:LSB_SET];
  // q3 pushes this edge, q2 next, new one after
  assign in_flight = FREE_W'(q2_valid_q) + FREE_W'(q3_valid_q);
  // same set as a stage that still writes its array
  assign hazard = (tag_wr_en && (q1_set == q2_set_q)) ||
                  (data_wr_en && (q1_set == q3_set_q));
  assign req_ready  = (rsp_free > in_flight) && !hazard;
  assign accept     = req_valid && req_ready;
  assign tag_rd_en  = accept;
  assign tag_rd_set = q1_set;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q2_valid_q <= 1'b0;
      q3_valid_q <= 1'b0;
    end else begin
      q2_valid_q <= accept;
      q3_valid_q <= q2_valid_q;
    end
  end

  // stage payload, qualified by the valid bits
  always_ff @(posedge clk) begin
    q2_op_q      <= req.lu_op;
    q2_tag_q     <= req.address[MSB_TAG:LSB_TAG];
    q2_set_q     <= q1_set;
    q2_offset_q  <= req.address[MSB_OFFSET:LSB_OFFSET];
    q2_data_q    <= req.data;
    q2_cl_data_q <= req.cl_data;
    q3_op_q      <= q2_op_q;
    q3_hit_q     <= q2_hit;
    q3_tag_q     <= q2_tag_q;
    q3_set_q     <= q2_set_q;
    q3_offset_q  <= q2_offset_q;
    q3_data_q    <= q2_data_q;
    q3_cl_data_q <= q2_cl_data_q;
    q3_way_q     <= q2_way;
  end

  // ====================
  // q2 compare and victim
  // ====================
  always_comb begin
    hit_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      hit_vec[w] = tag_rd_valid[w] && (tag_rd_tags[w] == q2_tag_q);
      if (hit_vec[w]) begin
        hit_way = WAY_WIDTH'(w);
      end
    end
  end
  assign q2_hit = |hit_vec;

  // first invalid way, else lowest way with MRU clear
  always_comb begin
    victim_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!tag_rd_mru[w]) begin
        victim_way = WAY_WIDTH'(w);
      end
    end
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!tag_rd_valid[w]) begin
        victim_way = WAY_WIDTH'(w);
      end
    end
  end

  // a fill that hits refreshes its own way
  assign q2_way     = (q2_op_q == FILL_LU && !q2_hit) ? victim_way : hit_way;
  assign way_onehot = {{(NUM_WAYS-1){1'b0}}, 1'b1} << q2_way;
  assign mru_set    = tag_rd_mru | way_onehot;

  // tag and MRU update on any hit or fill
  assign tag_wr_en       = q2_valid_q && (q2_hit || q2_op_q == FILL_LU);
  assign tag_wr_set      = q2_set_q;
  assign tag_wr_way_mask = (q2_op_q == FILL_LU) ? way_onehot : '0;
  assign tag_wr_tag      = q2_tag_q;
  // all MRU set collapses to the new way only
  assign tag_wr_mru      = (&mru_set) ? way_onehot : mru_set;

  assign data_rd_en   = q2_valid_q && q2_hit;
  assign data_rd_addr = {q2_set_q, q2_way};

  // ====================
  // q3 response and write
  // ====================
  assign rsp_valid       = q3_valid_q;
  assign rsp.lu_result   = !q3_valid_q                   ? NO_RSP :
                           (q3_op_q == FILL_LU || q3_hit_q) ? HIT : MISS;
  assign rsp.address     = {q3_tag_q, q3_set_q, q3_offset_q, 2'b00};
  assign rsp.data        = (q3_op_q == FILL_LU)            ? q3_cl_data_q :
                           (q3_op_q == RD_LU && q3_hit_q)  ? data_rd_line : '0;

  // word write into the line read in q2
  always_comb begin
    merged_line              = data_rd_line;
    merged_line[q3_offset_q] = q3_data_q;
  end

  assign data_wr_en   = q3_valid_q && (q3_op_q == FILL_LU || (q3_op_q == WR_LU && q3_hit_q));
  assign data_wr_addr = {q3_set_q, q3_way_q};
  assign data_wr_line = (q3_op_q == FILL_LU) ? q3_cl_data_q : merged_line;

endmodule

//--- design/cache_lookup_top.sv
// cache lookup top level
module cache_lookup_top
  import cache_lookup_pkg::*;
#(
  parameter int REQ_FIFO_DEPTH = 4,
  parameter int RSP_FIFO_DEPTH = 4
) (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    req_valid,
  output logic    req_ready,
  input  t_lu_req req_payload,
  output logic    rsp_valid,
  input  logic    rsp_ready,
  output t_lu_rsp rsp_payload
);

  localparam int RSP_CNT_W = $clog2(RSP_FIFO_DEPTH) + 1;

  // ====================
  // interconnect
  // ====================
  logic                                deq_valid;
  logic                                deq_ready;
  t_lu_req                             deq_payload;
  logic [RSP_CNT_W-1:0]                rsp_free;
  logic                                rsp_push_valid;
  t_lu_rsp                             rsp_push_payload;
  logic                                tag_rd_en;
  logic [SET_WIDTH-1:0]                tag_rd_set;
  logic [NUM_WAYS-1:0]                 tag_rd_valid;
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0]  tag_rd_tags;
  logic [NUM_WAYS-1:0]                 tag_rd_mru;
  logic                                tag_wr_en;
  logic [SET_WIDTH-1:0]                tag_wr_set;
  logic [NUM_WAYS-1:0]                 tag_wr_way_mask;
  logic [TAG_WIDTH-1:0]                tag_wr_tag;
  logic [NUM_WAYS-1:0]                 tag_wr_mru;
  logic                                data_rd_en;
  logic [SET_WIDTH+WAY_WIDTH-1:0]      data_rd_addr;
  t_cl                                 data_rd_line;
  logic                                data_wr_en;
  logic [SET_WIDTH+WAY_WIDTH-1:0]      data_wr_addr;
  t_cl                                 data_wr_line;

  // request buffer, its credit count is not needed
  lu_fifo #(.DEPTH(REQ_FIFO_DEPTH), .t_payload(t_lu_req)) u_req_fifo (
    .clk(clk), .arst_n(arst_n),
    .enq_valid(req_valid), .enq_ready(req_ready), .enq_payload(req_payload),
    .deq_valid(deq_valid), .deq_ready(deq_ready), .deq_payload(deq_payload),
    .free_count()
  );

  cache_pipe #(.RSP_FIFO_DEPTH(RSP_FIFO_DEPTH)) u_cache_pipe (
    .clk(clk), .arst_n(arst_n),
    .req_valid(deq_valid), .req_ready(deq_ready), .req(deq_payload),
    .rsp_free(rsp_free), .rsp_valid(rsp_push_valid), .rsp(rsp_push_payload),
    .tag_rd_en(tag_rd_en), .tag_rd_set(tag_rd_set), .tag_rd_valid(tag_rd_valid),
    .tag_rd_tags(tag_rd_tags), .tag_rd_mru(tag_rd_mru),
    .tag_wr_en(tag_wr_en), .tag_wr_set(tag_wr_set), .tag_wr_way_mask(tag_wr_way_mask),
    .tag_wr_tag(tag_wr_tag), .tag_wr_mru(tag_wr_mru),
    .data_rd_en(data_rd_en), .data_rd_addr(data_rd_addr), .data_rd_line(data_rd_line),
    .data_wr_en(data_wr_en), .data_wr_addr(data_wr_addr), .data_wr_line(data_wr_line)
  );

  tag_array u_tag_array (
    .clk(clk), .arst_n(arst_n),
    .rd_en(tag_rd_en), .rd_set(tag_rd_set), .rd_valid(tag_rd_valid),
    .rd_tags(tag_rd_tags), .rd_mru(tag_rd_mru),
    .wr_en(tag_wr_en), .wr_set(tag_wr_set), .wr_way_mask(tag_wr_way_mask),
    .wr_tag(tag_wr_tag), .wr_mru(tag_wr_mru)
  );

  data_array u_data_array (
    .clk(clk),
    .rd_en(data_rd_en), .rd_addr(data_rd_addr), .rd_line(data_rd_line),
    .wr_en(data_wr_en), .wr_addr(data_wr_addr), .wr_line(data_wr_line)
  );

  // pipe credit keeps pushes from ever being refused
  lu_fifo #(.DEPTH(RSP_FIFO_DEPTH), .t_payload(t_lu_rsp)) u_rsp_fifo (
    .clk(clk), .arst_n(arst_n),
    .enq_valid(rsp_push_valid), .enq_ready(), .enq_payload(rsp_push_payload),
    .deq_valid(rsp_valid), .deq_ready(rsp_ready), .deq_payload(rsp_payload),
    .free_count(rsp_free)
  );

endmodule

//--- testbench/lu_checker.sv
// response port checker
module lu_checker
  import cache_lookup_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    rsp_valid,
  input  logic    rsp_ready,
  input  t_lu_rsp rsp_payload,
  output logic    checks_done,
  output int      pass_total,
  output int      fail_count
);

  localparam int MAX_VECTORS = 40;
  localparam int REC_WORDS   = 6;

  // six words per record as in the driver
  logic [127:0] exp_mem [MAX_VECTORS*REC_WORDS];
  int           num_expected;
  int           rsp_idx;
  int           pass_count;
  int           fail_tests;

  assign checks_done = (num_expected > 0) && (rsp_idx >= num_expected);
  assign pass_total  = pass_count;
  assign fail_count  = fail_tests;

  // filler for words the file leaves unset
  function automatic logic [127:0] fill_word(input int addr);
    return ~128'(addr);
  endfunction

  // records end where the filler shows through
  function automatic int count_records();
    int n;
    n = 0;
    while (n < MAX_VECTORS && exp_mem[n*REC_WORDS] != fill_word(n*REC_WORDS)) begin
      n++;
    end
    return n;
  endfunction

  initial begin
    for (int i = 0; i < MAX_VECTORS * REC_WORDS; i++) begin
      exp_mem[i] = fill_word(i);
    end
    $readmemh("testbench/cache_vectors.hex", exp_mem);
    num_expected = count_records();
  end

  // ====================
  // field compare
  // ====================
  task automatic check_response(input int idx);
    int                    base;
    logic                  bad;
    logic [1:0]            exp_result;
    logic [ADDR_WIDTH-1:0] exp_addr;
    t_cl                   exp_line;
    base       = idx * REC_WORDS;
    bad        = 1'b0;
    exp_result = exp_mem[base+4][1:0];
    exp_addr   = exp_mem[base+1][ADDR_WIDTH-1:0];
    exp_line   = exp_mem[base+5];
    if (rsp_payload.lu_result !== exp_result) begin
      $display("MISMATCH at %0t: test %0d result expected %0d actual %0d",
               $time, idx, exp_result, rsp_payload.lu_result);
      bad = 1'b1;
    end
    if (rsp_payload.address !== exp_addr) begin
      $display("MISMATCH at %0t: test %0d address expected %h actual %h",
               $time, idx, exp_addr, rsp_payload.address);
      bad = 1'b1;
    end
    if (rsp_payload.data !== exp_line) begin
      $display("MISMATCH at %0t: test %0d data expected %h actual %h",
               $time, idx, exp_line, rsp_payload.data);
      bad = 1'b1;
    end
    if (bad) begin
      fail_tests++;
      $display("test %0d failed", idx);
    end else begin
      pass_count++;
      $display("test %0d ok: result %0d address %h", idx, exp_result, exp_addr);
    end
  endtask

  // ====================
  // response monitor
  // ====================
  // responses must come back in request order
  always @(posedge clk) begin
    if (arst_n && rsp_valid && rsp_ready) begin
      if (rsp_idx < num_expected) begin
        check_response(rsp_idx);
      end else begin
        $display("unexpected response after the last vector at time %0t", $time);
        fail_tests++;
      end
      rsp_idx++;
    end
  end

endmodule

//--- testbench/tb_cache_lookup.sv
// cache lookup testbench
module tb_cache_lookup
  import cache_lookup_pkg::*;
();

  localparam int MAX_VECTORS = 40;
  localparam int REC_WORDS   = 6;

  logic         clk = 1'b0;
  logic         arst_n;
  logic         req_valid;
  logic         req_ready;
  t_lu_req      req_payload;
  logic         rsp_valid;
  logic         rsp_ready;
  t_lu_rsp      rsp_payload;
  logic         checks_done;
  int           pass_total;
  int           fail_count;
  int           num_vectors;
  int           seed = 2410;
  // op, address, word, line, expected result, expected line
  logic [127:0] vec_mem [MAX_VECTORS*REC_WORDS];

  always #5 clk = ~clk;

  cache_lookup_top #(.REQ_FIFO_DEPTH(4), .RSP_FIFO_DEPTH(4)) dut (
    .clk(clk), .arst_n(arst_n),
    .req_valid(req_valid), .req_ready(req_ready), .req_payload(req_payload),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_payload(rsp_payload)
  );

  lu_checker u_checker (
    .clk(clk), .arst_n(arst_n),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_payload(rsp_payload),
    .checks_done(checks_done), .pass_total(pass_total), .fail_count(fail_count)
  );

  // filler for words the file leaves unset
  function automatic logic [127:0] fill_word(input int addr);
    return ~128'(addr);
  endfunction

  function automatic int count_vectors();
    int n;
    n = 0;
    while (n < MAX_VECTORS && vec_mem[n*REC_WORDS] != fill_word(n*REC_WORDS)) begin
      n++;
    end
    return n;
  endfunction

  // hold valid and payload until the FIFO takes them
  task automatic send_request(input int idx);
    int base;
    base = idx * REC_WORDS;
    req_valid           <= 1'b1;
    req_payload.lu_op   <= t_lu_op'(vec_mem[base][1:0]);
    req_payload.address <= vec_mem[base+1][ADDR_WIDTH-1:0];
    req_payload.data    <= vec_mem[base+2][WORD_WIDTH-1:0];
    req_payload.cl_data <= vec_mem[base+3];
    @(posedge clk);
    while (!req_ready) begin
      @(posedge clk);
    end
  endtask

  // ====================
  // request driver
  // ====================
  initial begin
    arst_n      = 1'b0;
    req_valid   = 1'b0;
    req_payload = '0;
    for (int i = 0; i < MAX_VECTORS * REC_WORDS; i++) begin
      vec_mem[i] = fill_word(i);
    end
    $readmemh("testbench/cache_vectors.hex", vec_mem);
    num_vectors = count_vectors();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < num_vectors; i++) begin
      send_request(i);
      // a few gaps early and one long burst in the second half
      if (i < num_vectors / 2 && i % 6 == 5) begin
        req_valid <= 1'b0;
        @(posedge clk);
      end
    end
    req_valid <= 1'b0;
  end

  // rsp_ready low about a third of the time
  initial begin
    rsp_ready = 1'b0;
    forever begin
      @(posedge clk);
      rsp_ready <= arst_n && (($random(seed) % 3) != 0);
    end
  end

  // ====================
  // run control
  // ====================
  initial begin
    int cycles;
    int limit;
    cycles = 0;
    @(posedge arst_n);
    limit = 20 * num_vectors + 100;
    while (!checks_done && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    // room for a stray extra response
    if (checks_done) begin
      repeat (10) @(posedge clk);
    end else begin
      $display("timeout after %0d cycles, responses are missing", cycles);
    end
    $display("checks done: %0d passed, %0d failed", pass_total, fail_count);
    if (checks_done && fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- cache_lookup.f
design/cache_lookup_pkg.sv
design/lu_fifo.sv
design/tag_array.sv
design/data_array.sv
design/cache_pipe.sv
design/cache_lookup_top.sv
testbench/lu_checker.sv
testbench/tb_cache_lookup.sv

//--- Makefile
TOP := tb_cache_lookup

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f cache_lookup.f --top-module $(TOP)

sim:
	verilator --binary --timing -f cache_lookup.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "TB FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- testbench/cache_vectors.hex
// op addr data cl_data exp_result exp_line, all hex, lines with word 3 first
// op 0 rd, 1 wr, 2 fill; result 0 hit, 1 miss
0 1230 00000000 00000000000000000000000000000000 1 00000000000000000000000000000000
0 45a8 00000000 00000000000000000000000000000000 1 00000000000000000000000000000000
2 1230 00000000 11110003111100021111000111110000 0 11110003111100021111000111110000
0 1238 00000000 00000000000000000000000000000000 0 11110003111100021111000111110000
1 1234 deadbeef 00000000000000000000000000000000 0 00000000000000000000000000000000
0 1230 00000000 00000000000000000000000000000000 0 1111000311110002deadbeef11110000
1 9930 cafef00d 00000000000000000000000000000000 1 00000000000000000000000000000000
0 9930 00000000 00000000000000000000000000000000 1 00000000000000000000000000000000
0 123c 00000000 00000000000000000000000000000000 0 1111000311110002deadbeef11110000
2 a170 00000000 a1000003a1000002a1000001a1000000 0 a1000003a1000002a1000001a1000000
2 a270 00000000 a2000003a2000002a2000001a2000000 0 a2000003a2000002a2000001a2000000
2 a370 00000000 a3000003a3000002a3000001a3000000 0 a3000003a3000002a3000001a3000000
2 a470 00000000 a4000003a4000002a4000001a4000000 0 a4000003a4000002a4000001a4000000
2 a570 00000000 a5000003a5000002a5000001a5000000 0 a5000003a5000002a5000001a5000000
0 a170 00000000 00000000000000000000000000000000 1 00000000000000000000000000000000
0 a270 00000000 00000000000000000000000000000000 0 a2000003a2000002a2000001a2000000
0 a370 00000000 00000000000000000000000000000000 0 a3000003a3000002a3000001a3000000
0 a470 00000000 00000000000000000000000000000000 0 a4000003a4000002a4000001a4000000
0 a570 00000000 00000000000000000000000000000000 0 a5000003a5000002a5000001a5000000
2 20b0 00000000 b0000003b0000002b0000001b0000000 0 b0000003b0000002b0000001b0000000
0 20b4 00000000 00000000000000000000000000000000 0 b0000003b0000002b0000001b0000000
1 20b8 0badf00d 00000000000000000000000000000000 0 00000000000000000000000000000000
0 1230 00000000 00000000000000000000000000000000 0 1111000311110002deadbeef11110000
0 a570 00000000 00000000000000000000000000000000 0 a5000003a5000002a5000001a5000000
2 30c0 00000000 c0000003c0000002c0000001c0000000 0 c0000003c0000002c0000001c0000000
0 20bc 00000000 00000000000000000000000000000000 0 b00000030badf00db0000001b0000000
0 30cc 00000000 00000000000000000000000000000000 0 c0000003c0000002c0000001c0000000
0 40d0 00000000 00000000000000000000000000000000 1 00000000000000000000000000000000
1 30c0 12345678 00000000000000000000000000000000 0 00000000000000000000000000000000
0 30c4 00000000 00000000000000000000000000000000 0 c0000003c0000002c000000112345678
0 a170 00000000 00000000000000000000000000000000 1 00000000000000000000000000000000
